// ==== dv/branch_predictor_assertions.sv ====
// checker bound into the predictor top
// keeps a shadow PHT stepped with the counter rules from bp_counter_pkg
// shadow writes land one cycle after the result strobe, lane 1 last
// index slice is fetch_pc bits 6..2 for the default geometry
// check_failed stays high after the first assertion failure
module branch_predictor_assertions (
    input logic                    clock,
    input logic                    reset,
    input logic                    is_branch,
    input bp_config_pkg::pc_t      fetch_pc,
    input logic                    pred_valid,
    input logic                    pred_taken,
    input bp_config_pkg::pht_idx_t pred_tag,
    input logic                    result_valid_0,
    input logic                    result_taken_0,
    input logic                    result_pred_0,
    input bp_config_pkg::pht_idx_t result_tag_0,
    input logic                    result_valid_1,
    input logic                    result_taken_1,
    input logic                    result_pred_1,
    input bp_config_pkg::pht_idx_t result_tag_1,
    input logic                    mispredict_0,
    input logic                    mispredict_1
);

    bp_counter_pkg::ctr_t    shadow_q [bp_config_pkg::bht_size]; // expected counters
    logic                    pend_valid_0; // results waiting for their table write
    logic                    pend_taken_0;
    bp_config_pkg::pht_idx_t pend_idx_0;
    logic                    pend_valid_1;
    logic                    pend_taken_1;
    bp_config_pkg::pht_idx_t pend_idx_1;
    logic                    exp_taken;    // expected pred_taken
    logic                    seen_update;  // any counter written since reset

    // one flag per assertion
    logic quiet_failed      = 1'b0;
    logic pipe_failed       = 1'b0;
    logic gate_failed       = 1'b0;
    logic shadow_failed     = 1'b0;
    logic cold_failed       = 1'b0;
    logic mispredict_failed = 1'b0;
    logic check_failed;

    assign check_failed = quiet_failed | pipe_failed | gate_failed
                        | shadow_failed | cold_failed | mispredict_failed;

    ////////////////////
    // shadow model
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < bp_config_pkg::bht_size; i++) begin
                shadow_q[i] <= bp_counter_pkg::ctr_reset;
            end
            pend_valid_0 <= 1'b0;
            pend_valid_1 <= 1'b0;
            exp_taken    <= 1'b0;
            seen_update  <= 1'b0;
        end else begin
            // both lanes read the old value
            if (pend_valid_0) begin
                shadow_q[pend_idx_0] <= bp_counter_pkg::ctr_next(shadow_q[pend_idx_0],
                                                                 pend_taken_0);
            end
            if (pend_valid_1) begin // later write wins on a clash
                shadow_q[pend_idx_1] <= bp_counter_pkg::ctr_next(shadow_q[pend_idx_1],
                                                                 pend_taken_1);
            end
            if (pend_valid_0 || pend_valid_1) begin
                seen_update <= 1'b1;
            end
            pend_valid_0 <= result_valid_0;
            pend_taken_0 <= result_taken_0;
            pend_idx_0   <= result_tag_0;
            pend_valid_1 <= result_valid_1;
            pend_taken_1 <= result_taken_1;
            pend_idx_1   <= result_tag_1;
            // lookup sees the table before this edge's write
            exp_taken <= is_branch && bp_counter_pkg::ctr_predict(shadow_q[fetch_pc[6:2]]);
        end
    end

    ////////////////////
    // assertions
    ////////////////////

    reset_quiet_a: assert property (@(posedge clock)
        $fell(reset) |-> !pred_valid && !mispredict_0 && !mispredict_1)
        else begin
            quiet_failed = 1'b1;
            $error("ERR %0t: outputs not clear after reset", $time);
        end

    // valid and tag are the previous cycle's strobe and PC slice
    lookup_pipe_a: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) |-> pred_valid == $past(is_branch)
                          && (!pred_valid || pred_tag == $past(fetch_pc[6:2])))
        else begin
            pipe_failed = 1'b1;
            $error("ERR %0t: pred_valid or pred_tag off by pipeline", $time);
        end

    taken_gated_a: assert property (@(posedge clock) disable iff (reset)
        pred_taken |-> pred_valid)
        else begin
            gate_failed = 1'b1;
            $error("ERR %0t: pred_taken high without pred_valid", $time);
        end

    taken_shadow_a: assert property (@(posedge clock) disable iff (reset)
        pred_valid |-> pred_taken == exp_taken)
        else begin
            shadow_failed = 1'b1;
            $error("ERR %0t: pred_taken %0b, shadow says %0b", $time, pred_taken, exp_taken);
        end

    cold_table_a: assert property (@(posedge clock) disable iff (reset)
        !seen_update |-> !pred_taken)
        else begin
            cold_failed = 1'b1;
            $error("ERR %0t: taken predicted before any update", $time);
        end

    mispredict_a: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) |->
            mispredict_0 == $past(result_valid_0 && (result_taken_0 != result_pred_0))
            && mispredict_1 == $past(result_valid_1 && (result_taken_1 != result_pred_1)))
        else begin
            mispredict_failed = 1'b1;
            $error("ERR %0t: mispredict flags %0b%0b wrong", $time, mispredict_1,
                   mispredict_0);
        end

endmodule : branch_predictor_assertions

bind branch_predictor_top branch_predictor_assertions assertions_i (
    .clock          (clock),
    .reset          (reset),
    .is_branch      (is_branch),
    .fetch_pc       (fetch_pc),
    .pred_valid     (pred_valid),
    .pred_taken     (pred_taken),
    .pred_tag       (pred_tag),
    .result_valid_0 (result_valid_0),
    .result_taken_0 (result_taken_0),
    .result_pred_0  (result_pred_0),
    .result_tag_0   (result_tag_0),
    .result_valid_1 (result_valid_1),
    .result_taken_1 (result_taken_1),
    .result_pred_1  (result_pred_1),
    .result_tag_1   (result_tag_1),
    .mispredict_0   (mispredict_0),
    .mispredict_1   (mispredict_1)
);

// ==== dv/branch_predictor_tb.sv ====
// directed and random regression for the branch direction predictor
// checking lives in the bound assertion module, this file only drives
// inputs change on the falling edge, the DUT samples on the rising edge
// random phase is fully repeatable from the fixed seed
module branch_predictor_tb;

    localparam int unsigned max_cycles = 2000; // run is about 800 cycles

    logic                    clock;
    logic                    reset;
    logic                    is_branch;
    bp_config_pkg::pc_t      fetch_pc;
    logic                    pred_valid;
    logic                    pred_taken;
    bp_config_pkg::pht_idx_t pred_tag;
    logic                    result_valid_0;
    logic                    result_taken_0;
    logic                    result_pred_0;
    bp_config_pkg::pht_idx_t result_tag_0;
    logic                    result_valid_1;
    logic                    result_taken_1;
    logic                    result_pred_1;
    bp_config_pkg::pht_idx_t result_tag_1;
    logic                    mispredict_0;
    logic                    mispredict_1;
    int                      seed;
    int unsigned             cycle_count = 0;

    tb_clock_gen clock_gen_i (.clock(clock));

    branch_predictor_top dut_i (.*);

    ////////////////////
    // stimulus helpers
    ////////////////////

    task automatic clear_inputs();
        is_branch      = 1'b0;
        fetch_pc       = '0;
        result_valid_0 = 1'b0;
        result_taken_0 = 1'b0;
        result_pred_0  = 1'b0;
        result_tag_0   = '0;
        result_valid_1 = 1'b0;
        result_taken_1 = 1'b0;
        result_pred_1  = 1'b0;
        result_tag_1   = '0;
    endtask

    task automatic next_cycle();
        @(negedge clock);
    endtask

    // random upper PC bits, index forced into 6..2
    task automatic send_lookup(input bp_config_pkg::pht_idx_t idx);
        logic [31:0] rnd;
        rnd       = $random(seed);
        is_branch = 1'b1;
        fetch_pc  = {rnd[31:7], idx, rnd[1:0]};
    endtask

    task automatic send_result_0(input bp_config_pkg::pht_idx_t tag, input logic taken,
                                 input logic pred);
        result_valid_0 = 1'b1;
        result_taken_0 = taken;
        result_pred_0  = pred;
        result_tag_0   = tag;
    endtask

    task automatic send_result_1(input bp_config_pkg::pht_idx_t tag, input logic taken,
                                 input logic pred);
        result_valid_1 = 1'b1;
        result_taken_1 = taken;
        result_pred_1  = pred;
        result_tag_1   = tag;
    endtask

    task automatic lookup_only(input bp_config_pkg::pht_idx_t idx, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            clear_inputs();
            send_lookup(idx);
            next_cycle();
        end
    endtask

    ////////////////////
    // watchdog
    ////////////////////

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    always @(negedge clock) begin
        if (dut_i.assertions_i.check_failed) begin
            $display("Regression failed");
            $fatal(1, "a bound assertion reported a mismatch");
        end else if (cycle_count >= max_cycles) begin
            $display("Regression failed");
            $fatal(1, "timeout, run did not finish within %0d cycles", max_cycles);
        end
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        logic [31:0]             rnd_a;
        logic [31:0]             rnd_b;
        bp_config_pkg::pht_idx_t hammer_idx;
        seed  = 32'h15b8;
        reset = 1'b1;
        clear_inputs();
        // live strobes under reset, outputs must still come out clear
        is_branch      = 1'b1;
        result_valid_0 = 1'b1;
        result_taken_0 = 1'b1;
        result_valid_1 = 1'b1;
        result_pred_1  = 1'b1;
        repeat (10) @(negedge clock); // 10 cycles of reset
        reset = 1'b0;

        // cold table, every entry must say not taken
        for (int i = 0; i < bp_config_pkg::bht_size; i++) begin
            clear_inputs();
            send_lookup(bp_config_pkg::pht_idx_t'(i));
            next_cycle();
        end

        // climb one entry to strong taken
        hammer_idx = 5'd9;
        for (int i = 0; i < 6; i++) begin
            clear_inputs();
            send_lookup(hammer_idx);
            send_result_0(hammer_idx, 1'b1, 1'b0);
            next_cycle();
        end
        clear_inputs();
        send_lookup(hammer_idx);
        send_result_1(hammer_idx, 1'b0, 1'b1); // single not taken from saturation
        next_cycle();
        lookup_only(hammer_idx, 3); // still taken
        for (int i = 0; i < 6; i++) begin
            clear_inputs();
            send_lookup(hammer_idx);
            send_result_0(hammer_idx, 1'b0, 1'b1); // down to the floor
            next_cycle();
        end
        lookup_only(hammer_idx, 3);

        // update visible two cycles after the strobe, not one
        clear_inputs();
        send_lookup(5'd20);
        send_result_0(5'd20, 1'b1, 1'b0);
        next_cycle();
        lookup_only(5'd20, 4);

        // same index on both lanes, lane 1 direction wins
        for (int i = 0; i < 4; i++) begin
            clear_inputs();
            send_lookup(5'd17);
            send_result_0(5'd17, 1'b1, 1'b1);
            send_result_1(5'd17, 1'b0, 1'b0);
            next_cycle();
        end
        lookup_only(5'd17, 2);
        for (int i = 0; i < 4; i++) begin
            clear_inputs();
            send_lookup(5'd17);
            send_result_0(5'd17, 1'b0, 1'b0);
            send_result_1(5'd17, 1'b1, 1'b1);
            next_cycle();
        end
        lookup_only(5'd17, 2);

        // random traffic, tags often squeezed into 8 entries for clashes
        for (int n = 0; n < 700; n++) begin
            rnd_a          = $random(seed);
            rnd_b          = $random(seed);
            clear_inputs();
            is_branch      = rnd_a[0];
            fetch_pc       = rnd_b;
            result_valid_0 = rnd_a[1];
            result_taken_0 = rnd_a[2];
            result_pred_0  = rnd_a[3];
            result_tag_0   = rnd_a[4] ? {2'b00, rnd_a[7:5]} : rnd_a[12:8];
            result_valid_1 = rnd_a[13];
            result_taken_1 = rnd_a[14];
            result_pred_1  = rnd_a[15];
            result_tag_1   = rnd_a[16] ? {2'b00, rnd_a[19:17]} : rnd_a[24:20];
            next_cycle();
        end

        // drain so the last results reach the checks
        clear_inputs();
        repeat (4) next_cycle();

        if (dut_i.assertions_i.check_failed) begin
            $display("Regression failed");
            $fatal(1, "a bound assertion reported a mismatch");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule : branch_predictor_tb

// ==== dv/tb_clock_gen.sv ====
// free running clock for the testbench
// period is 20 time units and there is no stop control
// clock starts low so the first rising edge is at 10
module tb_clock_gen (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always begin
        #10 clock = ~clock; // half period
    end

endmodule : tb_clock_gen

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the branch predictor regression with Verilator
# exit status is nonzero on any failure of the run
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module branch_predictor_tb -f tb.f -Mdir obj_dir

# keep running past an assertion so the testbench reports and stops itself
./obj_dir/Vbranch_predictor_tb +verilator+error+limit+100

// ==== source/bp_config_pkg.sv ====
// sizes and vector types for the branch direction predictor
// table size must stay a power of two, index is a plain PC slice
// no hashing with history, so aliasing between branches is expected
package bp_config_pkg;

    ////////////////////
    // table geometry
    ////////////////////

    localparam int unsigned bht_size = 32;               // counters in the PHT
    localparam int unsigned idx_w    = $clog2(bht_size); // 5 bits for 32 entries
    localparam int unsigned idx_lsb  = 2;                // skip byte offset of 4B insts

    ////////////////////
    // datapath widths
    ////////////////////

    localparam int unsigned xlen = 32;                   // fetch PC width

    // fetch PC as seen by the lookup stage
    typedef logic [xlen-1:0] pc_t;

    // PHT index, also handed out as the prediction tag
    // execute lanes bring it back unchanged on resolve
    typedef logic [idx_w-1:0] pht_idx_t;

endpackage : bp_config_pkg

// ==== source/bp_counter_pkg.sv ====
// 2-bit saturating counter encoding and update rule
// encoding is fixed at 00..11 from strong not taken to strong taken
// msb of the counter is the predicted direction
package bp_counter_pkg;

    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } ctr_t;

    // every entry starts weakly not taken
    localparam ctr_t ctr_reset = weak_not_taken;

    ////////////////////
    // update rule
    ////////////////////

    // one step up on taken and one step down on not taken
    function automatic ctr_t ctr_next(input ctr_t state, input logic taken);
        ctr_t next_state;
        case (state)
            strong_not_taken: next_state = taken ? weak_not_taken : strong_not_taken; // floor
            weak_not_taken:   next_state = taken ? weak_taken     : strong_not_taken;
            weak_taken:       next_state = taken ? strong_taken   : weak_not_taken;
            strong_taken:     next_state = taken ? strong_taken   : weak_taken;       // ceiling
            default:          next_state = ctr_reset; // x state only in sim
        endcase
        return next_state;
    endfunction

    // predicted direction of a counter
    function automatic logic ctr_predict(input ctr_t state);
        return (state == weak_taken) || (state == strong_taken);
    endfunction

endpackage : bp_counter_pkg

// ==== source/bp_update_if.sv ====
// two-lane PHT update bus from resolve to the table
// one cycle of valid means one counter step, there is no acknowledge
// both lanes may point at the same index in the same cycle
interface bp_update_if;

    logic                      valid_0; // lane 0 update strobe
    logic                      taken_0; // resolved direction
    bp_config_pkg::pht_idx_t   idx_0;   // entry to step

    logic                      valid_1; // lane 1 update strobe
    logic                      taken_1;
    bp_config_pkg::pht_idx_t   idx_1;

    // resolve stage drives the bus
    modport resolve (
        output valid_0, taken_0, idx_0,
        output valid_1, taken_1, idx_1
    );

    // table side only listens
    modport tbl (
        input valid_0, taken_0, idx_0,
        input valid_1, taken_1, idx_1
    );

endinterface : bp_update_if

// ==== source/branch_predictor_top.sv ====
// branch direction predictor top
// lookup to prediction is one cycle and resolve to table write is one cycle
// an update shows up in lookups two cycles after the result strobe
// all ports are plain strobes with no handshake
module branch_predictor_top (
    input  logic                    clock,
    input  logic                    reset,

    // fetch side
    input  logic                    is_branch,
    input  bp_config_pkg::pc_t      fetch_pc,
    output logic                    pred_valid,
    output logic                    pred_taken,
    output bp_config_pkg::pht_idx_t pred_tag,

    // execute lane 0
    input  logic                    result_valid_0,
    input  logic                    result_taken_0,
    input  logic                    result_pred_0,
    input  bp_config_pkg::pht_idx_t result_tag_0,

    // execute lane 1
    input  logic                    result_valid_1,
    input  logic                    result_taken_1,
    input  logic                    result_pred_1,
    input  bp_config_pkg::pht_idx_t result_tag_1,

    output logic                    mispredict_0,
    output logic                    mispredict_1
);

    bp_config_pkg::pht_idx_t lookup_idx;   // predict to PHT
    logic                    lookup_taken; // PHT answer

    bp_update_if upd_bus (); // resolve to PHT

    ////////////////////
    // stages
    ////////////////////

    predict_stage predict_stage_i (
        .clock        (clock),
        .reset        (reset),
        .is_branch    (is_branch),
        .fetch_pc     (fetch_pc),
        .lookup_idx   (lookup_idx),
        .lookup_taken (lookup_taken),
        .pred_valid   (pred_valid),
        .pred_taken   (pred_taken),
        .pred_tag     (pred_tag)
    );

    dirp_pht dirp_pht_i (
        .clock        (clock),
        .reset        (reset),
        .lookup_idx   (lookup_idx),
        .lookup_taken (lookup_taken),
        .upd          (upd_bus.tbl)
    );

    resolve_stage resolve_stage_i (
        .clock          (clock),
        .reset          (reset),
        .result_valid_0 (result_valid_0),
        .result_taken_0 (result_taken_0),
        .result_pred_0  (result_pred_0),
        .result_tag_0   (result_tag_0),
        .result_valid_1 (result_valid_1),
        .result_taken_1 (result_taken_1),
        .result_pred_1  (result_pred_1),
        .result_tag_1   (result_tag_1),
        .mispredict_0   (mispredict_0),
        .mispredict_1   (mispredict_1),
        .upd            (upd_bus.resolve)
    );

endmodule : branch_predictor_top

// ==== source/dirp_pht.sv ====
// pattern history table of 2-bit saturating counters
// lookup is combinational off the stored counters
// updates land at the clock edge so a lookup in the same cycle sees the old value
// same-index dual update keeps only lane 1, both lanes step from the old value
module dirp_pht (
    input  logic                    clock,
    input  logic                    reset,

    // lookup path
    input  bp_config_pkg::pht_idx_t lookup_idx,
    output logic                    lookup_taken,

    // update path
    bp_update_if.tbl                upd
);

    ////////////////////
    // storage
    ////////////////////

    bp_counter_pkg::ctr_t pht_q [bp_config_pkg::bht_size]; // one counter per entry

    // stepped value per lane, both from the registered counter
    bp_counter_pkg::ctr_t upd_next_0;
    bp_counter_pkg::ctr_t upd_next_1;

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        upd_next_0 = bp_counter_pkg::ctr_next(pht_q[upd.idx_0], upd.taken_0);
        upd_next_1 = bp_counter_pkg::ctr_next(pht_q[upd.idx_1], upd.taken_1);
    end

    // lane 1 written after lane 0
    // on an index match its value is the one that sticks
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < bp_config_pkg::bht_size; i++) begin
                pht_q[i] <= bp_counter_pkg::ctr_reset; // weakly not taken
            end
        end else begin
            if (upd.valid_0) begin
                pht_q[upd.idx_0] <= upd_next_0;
            end
            if (upd.valid_1) begin
                pht_q[upd.idx_1] <= upd_next_1; // overrides lane 0 on clash
            end
        end
    end

    ////////////////////
    // lookup
    ////////////////////

    // msb decides, no bypass of an update in flight
    assign lookup_taken = bp_counter_pkg::ctr_predict(pht_q[lookup_idx]);

endmodule : dirp_pht

// ==== source/predict_stage.sv ====
// lookup stage of the direction predictor
// index is a straight PC slice starting at idx_lsb
// outputs are registered, one cycle after the fetch strobe
// a non-branch never reports taken
module predict_stage (
    input  logic                    clock,
    input  logic                    reset,

    // from fetch
    input  logic                    is_branch,
    input  bp_config_pkg::pc_t      fetch_pc,

    // to and from the PHT
    output bp_config_pkg::pht_idx_t lookup_idx,
    input  logic                    lookup_taken,

    // registered prediction
    output logic                    pred_valid,
    output logic                    pred_taken,
    output bp_config_pkg::pht_idx_t pred_tag
);

    ////////////////////
    // index slice
    ////////////////////

    // bits 6..2 for the default geometry
    assign lookup_idx = fetch_pc[bp_config_pkg::idx_lsb +: bp_config_pkg::idx_w];

    ////////////////////
    // output regs
    ////////////////////

    // control bits cleared in reset
    always_ff @(posedge clock) begin
        if (reset) begin
            pred_valid <= 1'b0;
            pred_taken <= 1'b0;
        end else begin
            pred_valid <= is_branch;
            pred_taken <= is_branch & lookup_taken; // gate by strobe
        end
    end

    // tag is payload
    // only meaningful with pred_valid
    always_ff @(posedge clock) begin
        pred_tag <= lookup_idx; // goes down the pipe with the branch
    end

endmodule : predict_stage

// ==== source/resolve_stage.sv ====
// resolve stage for two execute lanes
// registers returned branches onto the PHT update bus
// mispredict flags come out in the same register stage as the update
// both lanes are accepted every cycle, no back-pressure
module resolve_stage (
    input  logic                    clock,
    input  logic                    reset,

    // lane 0 result
    input  logic                    result_valid_0,
    input  logic                    result_taken_0, // actual direction
    input  logic                    result_pred_0,  // direction that was predicted
    input  bp_config_pkg::pht_idx_t result_tag_0,

    // lane 1 result
    input  logic                    result_valid_1,
    input  logic                    result_taken_1,
    input  logic                    result_pred_1,
    input  bp_config_pkg::pht_idx_t result_tag_1,

    // registered flags
    output logic                    mispredict_0,
    output logic                    mispredict_1,

    // to the PHT
    bp_update_if.resolve            upd
);

    ////////////////////
    // valid and flags
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            upd.valid_0  <= 1'b0;
            upd.valid_1  <= 1'b0;
            mispredict_0 <= 1'b0;
            mispredict_1 <= 1'b0;
        end else begin
            upd.valid_0  <= result_valid_0;
            upd.valid_1  <= result_valid_1;
            // wrong direction only counts on a live result
            mispredict_0 <= result_valid_0 & (result_taken_0 ^ result_pred_0);
            mispredict_1 <= result_valid_1 & (result_taken_1 ^ result_pred_1);
        end
    end

    ////////////////////
    // update payload
    ////////////////////

    // no reset on payload
    // qualified by the valid bits above
    always_ff @(posedge clock) begin
        upd.taken_0 <= result_taken_0;
        upd.idx_0   <= result_tag_0;  // tag is the PHT index
        upd.taken_1 <= result_taken_1;
        upd.idx_1   <= result_tag_1;
    end

endmodule : resolve_stage

// ==== tb.f ====
source/bp_config_pkg.sv
source/bp_counter_pkg.sv
source/bp_update_if.sv
source/dirp_pht.sv
source/predict_stage.sv
source/resolve_stage.sv
source/branch_predictor_top.sv
dv/tb_clock_gen.sv
dv/branch_predictor_assertions.sv
dv/branch_predictor_tb.sv
